// ==== axi_w_pkg.sv ====
// Bus widths, FIFO depths, burst and response codes, AXI write channel structs
package axi_w_pkg;

    // --------------------------------------------------
    // Bus widths
    // --------------------------------------------------
    localparam int data_w = 32;
    localparam int addr_w = 16;
    localparam int id_w = 4;
    localparam int len_w = 8;
    localparam int size_w = 3;
    localparam int strb_w = data_w / 8;
    // Largest AWSIZE the bus can carry
    localparam int bytes_log2 = $clog2(strb_w);

    // Buffer depths per channel
    localparam int aw_depth = 4;
    localparam int w_depth = 16;
    localparam int b_depth = 4;

    // Address bit that flips on a 4 KB page change
    localparam int page_bit = 12;

    // --------------------------------------------------
    // Burst and response codes
    // --------------------------------------------------
    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01,
        burst_wrap  = 2'b10,
        burst_rsvd  = 2'b11
    } burst_e;

    localparam logic [1:0] resp_okay = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // --------------------------------------------------
    // Channel payloads
    // --------------------------------------------------
    // One AW request
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [addr_w-1:0] addr;
        logic [len_w-1:0]  len;
        logic [size_w-1:0] size;
        burst_e            burst;
    } aw_req_t;

    // One W beat
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } w_beat_t;

    // One B response
    typedef struct packed {
        logic [id_w-1:0] id;
        logic [1:0]      resp;
    } b_resp_t;

    // User port payload, valid on each write strobe
    typedef struct packed {
        logic [id_w-1:0]   id;
        logic [len_w-1:0]  len;
        logic [size_w-1:0] size;
        burst_e            burst;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [strb_w-1:0] strb;
        logic              last;
    } user_wr_t;

endpackage

// ==== sync_fifo.sv ====
// Synchronous show-ahead FIFO with a type-parameter payload and full/empty flags
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t din,
    output logic     full,
    input  logic     pop,
    output payload_t dout,
    output logic     empty
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    // Occupancy, 0 to depth
    logic [cnt_w-1:0] count;
    logic do_push;
    logic do_pop;

    // Pointer step with wrap at depth
    function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == cnt_w'(depth));
    assign empty = (count == '0);
    // Overflow and underflow requests are dropped here
    assign do_push = push && !full;
    assign do_pop = pop && !empty;
    // Head entry shown without a read cycle
    assign dout = mem[rd_ptr];

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

// ==== burst_addr_calc.sv ====
// Next beat address for FIXED and INCR bursts with alignment and 4 KB bounding
`timescale 1ns/1ps

module burst_addr_calc (
    input  logic [axi_w_pkg::addr_w-1:0] start_addr,
    input  logic [axi_w_pkg::addr_w-1:0] cur_addr,
    input  logic [axi_w_pkg::size_w-1:0] size,
    input  axi_w_pkg::burst_e            burst,
    input  logic                         first,
    output logic [axi_w_pkg::addr_w-1:0] next_addr,
    output logic                         crosses_4kb
);

    import axi_w_pkg::*;

    logic [addr_w-1:0] align_mask;
    logic [addr_w-1:0] aligned_addr;
    logic [addr_w-1:0] addr_inc;
    logic [addr_w-1:0] base_addr;
    logic [addr_w-1:0] sum_addr;

    // --------------------------------------------------
    // Alignment
    // --------------------------------------------------
    // Clear the low size bits of the start address
    assign align_mask = {addr_w{1'b1}} << size;
    assign aligned_addr = start_addr & align_mask;

    // --------------------------------------------------
    // Increment
    // --------------------------------------------------
    // FIXED stays on the aligned start
    // INCR steps by 2^size bytes, WRAP and reserved follow INCR
    assign addr_inc = (burst == burst_fixed) ? '0 : (addr_w'(1) << size);

    // Beat 1 is counted from the aligned start
    // Unaligned offset of beat 0 is dropped there
    assign base_addr = first ? aligned_addr : cur_addr;
    assign sum_addr = base_addr + addr_inc;

    // --------------------------------------------------
    // 4 KB bounding
    // --------------------------------------------------
    // Page bit must match the start of the burst
    assign crosses_4kb = (sum_addr[page_bit] != start_addr[page_bit]);

    // Hold the base on a crossing so the beat stays in the start page
    assign next_addr = crosses_4kb ? base_addr : sum_addr;

endmodule

// ==== write_burst_ctrl.sv ====
// Burst phase FSM, beat counter, request latch, B response and user port drive
`timescale 1ns/1ps

module write_burst_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  axi_w_pkg::aw_req_t  aw_head,
    input  logic                aw_empty,
    input  axi_w_pkg::w_beat_t  w_head,
    input  logic                w_empty,
    input  logic                b_full,
    output logic                aw_pop,
    output logic                w_pop,
    output logic                b_push,
    output axi_w_pkg::b_resp_t  b_entry,
    output logic                we,
    output axi_w_pkg::user_wr_t wr,
    output logic                err_4kb
);

    import axi_w_pkg::*;

    // Beats move in first and burst, responses go out in first, burst or resp
    typedef enum logic [1:0] {
        ph_idle  = 2'b00,
        ph_first = 2'b01,
        ph_burst = 2'b10,
        ph_resp  = 2'b11
    } phase_e;

    phase_e phase;
    phase_e phase_nxt;
    aw_req_t req_q;
    aw_req_t cur_req;
    logic [len_w-1:0] beat_cnt;
    logic [addr_w-1:0] beat_addr;
    // Registered beat address is a held one
    logic addr_held;
    logic [addr_w-1:0] next_addr;
    logic crosses_4kb;
    logic in_first;
    logic last_beat;
    logic size_err;

    // --------------------------------------------------
    // Request select and FIFO pops
    // --------------------------------------------------
    assign in_first = (phase == ph_first);
    // FIFO head in first, latched copy afterwards
    assign cur_req = in_first ? aw_head : req_q;

    // AW and beat 0 leave their FIFOs together
    assign aw_pop = in_first && !aw_empty && !w_empty;
    // Empty W FIFO stalls the burst
    assign w_pop = aw_pop || ((phase == ph_burst) && !w_empty);

    // Beat count is len+1, WLAST ignored
    assign last_beat = (aw_pop && (aw_head.len == '0)) ||
                       ((phase == ph_burst) && w_pop && (beat_cnt == req_q.len));

    // --------------------------------------------------
    // Write response
    // --------------------------------------------------
    assign size_err = (cur_req.size > size_w'(bytes_log2));
    assign b_entry.id = cur_req.id;
    assign b_entry.resp = size_err ? resp_slverr : resp_okay;
    // Pushed with the last beat, or later from resp once B has room
    assign b_push = !b_full && (last_beat || (phase == ph_resp));

    // --------------------------------------------------
    // Phase FSM
    // --------------------------------------------------
    always_comb begin
        phase_nxt = phase;
        case (phase)
            ph_idle: begin
                phase_nxt = ph_first;
            end
            ph_first: begin
                if (aw_pop && (aw_head.len != '0)) begin
                    phase_nxt = ph_burst;
                end else if (aw_pop && b_full) begin
                    phase_nxt = ph_resp;
                end
            end
            ph_burst: begin
                if (last_beat) begin
                    phase_nxt = b_full ? ph_resp : ph_first;
                end
            end
            ph_resp: begin
                if (!b_full) begin
                    phase_nxt = ph_first;
                end
            end
            default: phase_nxt = ph_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= ph_idle;
            beat_cnt <= '0;
            addr_held <= 1'b0;
        end else begin
            phase <= phase_nxt;
            if (w_pop) begin
                // Count restarts at 1 after beat 0
                beat_cnt <= in_first ? len_w'(1) : beat_cnt + 1'b1;
                addr_held <= crosses_4kb;
            end
        end
    end

    // Request copy and address of the next beat
    always_ff @(posedge clk) begin
        if (aw_pop) begin
            req_q <= aw_head;
        end
        if (w_pop) begin
            beat_addr <= next_addr;
        end
    end

    burst_addr_calc u_addr_calc (
        .start_addr  (cur_req.addr),
        .cur_addr    (beat_addr),
        .size        (cur_req.size),
        .burst       (cur_req.burst),
        .first       (in_first),
        .next_addr   (next_addr),
        .crosses_4kb (crosses_4kb)
    );

    // --------------------------------------------------
    // User port
    // --------------------------------------------------
    assign we = w_pop;
    assign wr.id = cur_req.id;
    assign wr.len = cur_req.len;
    assign wr.size = cur_req.size;
    assign wr.burst = cur_req.burst;
    // Beat 0 carries the raw request address
    assign wr.addr = in_first ? aw_head.addr : beat_addr;
    assign wr.data = w_head.data;
    assign wr.strb = we ? w_head.strb : '0;
    assign wr.last = we ? w_head.last : 1'b0;
    // Flag only the beats whose address was held
    assign err_4kb = (phase == ph_burst) && we && addr_held;

endmodule

// ==== axi_slave_wr.sv ====
// AXI4 write slave top with AW, W and B FIFOs around the burst controller
`timescale 1ns/1ps

module axi_slave_wr (
    input  logic                clk,
    input  logic                rst_n,
    // AW channel
    input  axi_w_pkg::aw_req_t  aw,
    input  logic                awvalid,
    output logic                awready,
    // W channel
    input  axi_w_pkg::w_beat_t  w,
    input  logic                wvalid,
    output logic                wready,
    // B channel
    output axi_w_pkg::b_resp_t  b,
    output logic                bvalid,
    input  logic                bready,
    // User port
    output logic                we,
    output axi_w_pkg::user_wr_t wr,
    output logic                err_4kb
);

    import axi_w_pkg::*;

    aw_req_t aw_head;
    logic aw_full;
    logic aw_empty;
    logic aw_pop;
    w_beat_t w_head;
    logic w_full;
    logic w_empty;
    logic w_pop;
    b_resp_t b_entry;
    logic b_push;
    logic b_full;
    logic b_empty;

    // --------------------------------------------------
    // AXI handshakes
    // --------------------------------------------------
    assign awready = !aw_full;
    assign wready = !w_full;
    assign bvalid = !b_empty;

    // Outstanding requests
    sync_fifo #(
        .payload_t (aw_req_t),
        .depth     (aw_depth)
    ) u_aw_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (awvalid && awready),
        .din   (aw),
        .full  (aw_full),
        .pop   (aw_pop),
        .dout  (aw_head),
        .empty (aw_empty)
    );

    // Write beats
    sync_fifo #(
        .payload_t (w_beat_t),
        .depth     (w_depth)
    ) u_w_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (wvalid && wready),
        .din   (w),
        .full  (w_full),
        .pop   (w_pop),
        .dout  (w_head),
        .empty (w_empty)
    );

    // Responses, head stays on b until bready
    sync_fifo #(
        .payload_t (b_resp_t),
        .depth     (b_depth)
    ) u_b_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (b_push),
        .din   (b_entry),
        .full  (b_full),
        .pop   (bvalid && bready),
        .dout  (b),
        .empty (b_empty)
    );

    write_burst_ctrl u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .aw_head  (aw_head),
        .aw_empty (aw_empty),
        .w_head   (w_head),
        .w_empty  (w_empty),
        .b_full   (b_full),
        .aw_pop   (aw_pop),
        .w_pop    (w_pop),
        .b_push   (b_push),
        .b_entry  (b_entry),
        .we       (we),
        .wr       (wr),
        .err_4kb  (err_4kb)
    );

endmodule

// ==== axi_slave_wr_properties.sv ====
// Concurrent checks on B hold, user strobe masking and AW acceptance, bound to the top
`timescale 1ns/1ps

module axi_slave_wr_properties (
    input logic                clk,
    input logic                rst_n,
    input logic                awready,
    input logic                aw_pop,
    input axi_w_pkg::b_resp_t  b,
    input logic                bvalid,
    input logic                bready,
    input logic                we,
    input axi_w_pkg::user_wr_t wr
);

    // --------------------------------------------------
    // B channel
    // --------------------------------------------------
    // A waiting response keeps its value until bready
    b_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        (bvalid && !bready) |=> (bvalid && $stable(b)))
        else $error("bvalid dropped or b changed while bready was low");

    // --------------------------------------------------
    // User port and AW channel
    // --------------------------------------------------
    // No byte enables outside a write strobe
    strb_mask_a: assert property (@(posedge clk) disable iff (!rst_n)
        !we |-> (wr.strb == '0))
        else $error("wr.strb nonzero while we is low");

    // Full AW FIFO frees a slot on a pop unless an AW slipped in
    aw_block_a: assert property (@(posedge clk) disable iff (!rst_n)
        (!awready && aw_pop) |=> awready)
        else $error("AW accepted while awready was low");

endmodule

bind axi_slave_wr axi_slave_wr_properties u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .awready (awready),
    .aw_pop  (aw_pop),
    .b       (b),
    .bvalid  (bvalid),
    .bready  (bready),
    .we      (we),
    .wr      (wr)
);

// ==== tb_axi_slave_wr.sv ====
// Testbench top: clock, reset, directed write bursts, compare tasks, timeout and summary
`timescale 1ns/1ps

module tb_axi_slave_wr;

    import axi_w_pkg::*;

    // Twenty beats over all tests, a hundred cycles allowed per beat
    localparam int total_beats = 20;
    localparam int timeout_cycles = total_beats * 100;
    localparam int bp_writes = 6;

    logic clk;
    logic rst_n;
    aw_req_t aw;
    logic awvalid;
    logic awready;
    w_beat_t w;
    logic wvalid;
    logic wready;
    b_resp_t b;
    logic bvalid;
    logic bready;
    logic we;
    user_wr_t wr;
    logic err_4kb;

    integer seed;
    int errors;
    int cycles = 0;
    string test_name;
    // Expected and observed traffic, in arrival order
    user_wr_t exp_wr[$];
    user_wr_t got_wr[$];
    logic exp_err[$];
    logic got_err[$];
    b_resp_t exp_b[$];
    b_resp_t got_b[$];
    // W beats planned but not yet driven
    w_beat_t w_todo[$];

    axi_slave_wr i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready),
        .we      (we),
        .wr      (wr),
        .err_4kb (err_4kb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: DUT still busy after %0d cycles in %s", cycles, test_name);
            $display("Test failures found");
            $finish;
        end
    end

    // --------------------------------------------------
    // Monitors, sampled mid-cycle
    // --------------------------------------------------
    always @(negedge clk) begin
        if (we) begin
            got_wr.push_back(wr);
            got_err.push_back(err_4kb);
        end
        // Handshake completes on the coming rising edge
        if (bvalid && bready) begin
            got_b.push_back(b);
        end
    end

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_wr(input string name, input user_wr_t exp_v, input user_wr_t act_v);
        if (exp_v !== act_v) begin
            errors++;
            $display("ERR %0t %s exp %h got %h (%s)", $time, name, exp_v, act_v, test_name);
        end
    endtask

    task automatic check_b(input string name, input b_resp_t exp_v, input b_resp_t act_v);
        if (exp_v !== act_v) begin
            errors++;
            $display("ERR %0t %s exp %h got %h (%s)", $time, name, exp_v, act_v, test_name);
        end
    endtask

    task automatic compare_flag(input string name, input logic exp_v, input logic act_v);
        if (exp_v !== act_v) begin
            errors++;
            $display("ERR %0t %s exp %b got %b (%s)", $time, name, exp_v, act_v, test_name);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("Failure in %s: %s", test_name, what);
    endtask

    // --------------------------------------------------
    // Reference model and drivers
    // --------------------------------------------------
    function automatic aw_req_t make_req(input logic [id_w-1:0] id,
                                         input logic [addr_w-1:0] addr,
                                         input logic [len_w-1:0] len,
                                         input logic [size_w-1:0] size,
                                         input burst_e burst);
        return '{id, addr, len, size, burst};
    endfunction

    // Random W beats plus the user beats and response they should produce
    task automatic plan_burst(input aw_req_t req);
        logic [addr_w-1:0] aligned;
        logic [addr_w-1:0] step;
        logic [addr_w-1:0] addr;
        logic [addr_w-1:0] nominal;
        logic held;
        int n;
        int rnd;
        w_beat_t beat;
        user_wr_t exp_beat;
        b_resp_t exp_resp;
        aligned = (req.addr >> req.size) << req.size;
        // FIXED never moves off the aligned start
        step = (req.burst == burst_fixed) ? '0 : (addr_w'(1) << req.size);
        addr = req.addr;
        held = 1'b0;
        for (n = 0; n <= int'(req.len); n++) begin
            // Later beats sit n steps above the aligned start
            if (n > 0) begin
                nominal = aligned + addr_w'(n) * step;
                held = (nominal[page_bit] != req.addr[page_bit]);
                // A held beat repeats the previous address, beat 1 falls back to the aligned start
                if (!held) begin
                    addr = nominal;
                end else if (n == 1) begin
                    addr = aligned;
                end
            end
            rnd = $random(seed);
            beat.data = $random(seed);
            beat.strb = rnd[strb_w-1:0];
            beat.last = (n == int'(req.len));
            w_todo.push_back(beat);
            // Field order of user_wr_t
            exp_beat = {req.id, req.len, req.size, req.burst, addr, beat.data, beat.strb,
                        beat.last};
            exp_wr.push_back(exp_beat);
            exp_err.push_back(held);
        end
        exp_resp.id = req.id;
        // Beat wider than the data bus
        exp_resp.resp = ((1 << int'(req.size)) > strb_w) ? resp_slverr : resp_okay;
        exp_b.push_back(exp_resp);
    endtask

    // Called 2 ns after a rising edge, returns 2 ns after the accepting edge
    task automatic send_aw(input aw_req_t req);
        logic taken;
        taken = 1'b0;
        aw = req;
        awvalid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = awready;
            @(posedge clk);
            #2;
        end
        awvalid = 1'b0;
    endtask

    task automatic send_w(input int count);
        logic taken;
        int i;
        for (i = 0; i < count; i++) begin
            w = w_todo.pop_front();
            wvalid = 1'b1;
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = wready;
                @(posedge clk);
                #2;
            end
        end
        wvalid = 1'b0;
    endtask

    task automatic issue_write(input aw_req_t req);
        plan_burst(req);
        send_aw(req);
        send_w(int'(req.len) + 1);
    endtask

    // Done once every expected beat and response has been seen
    task automatic wait_done();
        while ((got_wr.size() < exp_wr.size()) || (got_b.size() < exp_b.size())) begin
            @(posedge clk);
        end
        #2;
    endtask

    task automatic compare_all();
        while ((exp_wr.size() > 0) && (got_wr.size() > 0)) begin
            check_wr("wr", exp_wr.pop_front(), got_wr.pop_front());
            compare_flag("err_4kb", exp_err.pop_front(), got_err.pop_front());
        end
        while ((exp_b.size() > 0) && (got_b.size() > 0)) begin
            check_b("b", exp_b.pop_front(), got_b.pop_front());
        end
        if ((exp_wr.size() != got_wr.size()) || (exp_b.size() != got_b.size())) begin
            note_failure("number of user beats or responses differs from the expected count");
        end
        exp_wr.delete();
        got_wr.delete();
        exp_err.delete();
        got_err.delete();
        exp_b.delete();
        got_b.delete();
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic single_beat_write();
        test_name = "single beat";
        issue_write(make_req(4'h3, 16'h0105, 8'd0, 3'd2, burst_incr));
        wait_done();
        compare_all();
    endtask

    task automatic narrow_incr_burst();
        test_name = "narrow incr";
        // Halfword beats from an odd address
        issue_write(make_req(4'h5, 16'h0231, 8'd3, 3'd1, burst_incr));
        wait_done();
        compare_all();
    endtask

    task automatic fixed_burst();
        test_name = "fixed";
        issue_write(make_req(4'h7, 16'h0342, 8'd2, 3'd2, burst_fixed));
        wait_done();
        compare_all();
    endtask

    task automatic oversize_burst();
        test_name = "oversize";
        // 8-byte beats on a 4-byte bus
        issue_write(make_req(4'h8, 16'h0404, 8'd1, 3'd3, burst_incr));
        wait_done();
        compare_all();
    endtask

    task automatic page_cross_burst();
        test_name = "4kb crossing";
        // Beats 2 and 3 would land in the next page
        issue_write(make_req(4'h9, 16'h0ff8, 8'd3, 3'd2, burst_incr));
        wait_done();
        compare_all();
    endtask

    task automatic bready_backpressure();
        aw_req_t reqs[bp_writes];
        int i;
        test_name = "back-pressure";
        bready = 1'b0;
        for (i = 0; i < bp_writes; i++) begin
            reqs[i] = make_req(id_w'(10 + i), addr_w'(32'h0500 + 4 * i), 8'd0, 3'd2,
                               burst_incr);
            plan_burst(reqs[i]);
        end
        // Without W beats the controller cannot drain the AW FIFO
        for (i = 0; i < aw_depth; i++) begin
            send_aw(reqs[i]);
        end
        @(negedge clk);
        compare_flag("awready", 1'b0, awready);
        @(posedge clk);
        #2;
        send_w(aw_depth);
        // B FIFO is full by now, the fifth write waits in the response phase
        for (i = aw_depth; i < bp_writes; i++) begin
            send_aw(reqs[i]);
            send_w(1);
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        compare_flag("bvalid", 1'b1, bvalid);
        // Fifth write holds the controller, the sixth waits behind it
        if (got_wr.size() != b_depth + 1) begin
            note_failure("controller kept writing while the B FIFO was full");
        end
        @(posedge clk);
        #2;
        bready = 1'b1;
        wait_done();
        compare_all();
    endtask

    initial begin
        seed = 32'h5aef;
        errors = 0;
        test_name = "reset";
        rst_n = 1'b0;
        aw = '0;
        awvalid = 1'b0;
        w = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // Idle state of the ports right after reset
        @(negedge clk);
        compare_flag("awready", 1'b1, awready);
        compare_flag("wready", 1'b1, wready);
        compare_flag("bvalid", 1'b0, bvalid);
        compare_flag("we", 1'b0, we);
        compare_flag("err_4kb", 1'b0, err_4kb);
        @(posedge clk);
        #2;
        single_beat_write();
        narrow_incr_burst();
        fixed_burst();
        oversize_burst();
        page_cross_burst();
        bready_backpressure();
        $display("Summary: %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== files.f ====
axi_w_pkg.sv
sync_fifo.sv
burst_addr_calc.sv
write_burst_ctrl.sv
axi_slave_wr.sv
axi_slave_wr_properties.sv
tb_axi_slave_wr.sv

// ==== Makefile ====
# Verilator build and run of the AXI write slave testbench

SIM      ?= verilator
FLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      ?= tb_axi_slave_wr
FILELIST ?= files.f
OBJ_DIR  ?= obj_dir
PASS_MSG := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
